//--- verification/completion_patterns.txt
# columns: command, then its arguments; unit 0 ld, 1 alu, 2 st; seq counts allocations
# alloc dest store | result unit seq value_hex | idle cycles | reject dest store | full f | stalled f | drain
alloc 3 0
alloc 0 0
alloc 5 1
alloc 0 1
result 1 3 a0000003
idle 3
result 2 2 a0000002
idle 3
result 0 1 a0000001
idle 3
result 1 0 a0000000
drain
alloc 1 0
alloc 2 1
alloc 0 0
alloc 4 0
alloc 5 0
alloc 6 1
alloc 7 0
alloc 31 0
full 1
reject 9 0
result 0 4 0000c004
result 1 5 0000c005
result 2 6 0000c006
result 0 7 0000c007
result 1 8 0000c008
result 2 9 0000c009
result 0 10 0000c00a
result 1 11 0000c00b
stalled 1
drain
full 0

//--- completion.f
hw/completion_pkg.sv
hw/wb_req_if.sv
hw/wb_slot.sv
hw/cdb_arbiter.sv
hw/rob.sv
hw/completion_unit.sv
verification/completion_chk.sv
verification/completion_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the completion testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module completion_tb -f completion.f -o completion_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/completion_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
echo "simulation finished cleanly"
exit 0

//--- verification/completion_tb.sv
/*
 * pattern-driven testbench for completion_unit, run from the project root
 * result lines name an allocation by its sequence number, counted from zero
 */
`timescale 1ns/10ps

module completion_tb import completion_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 500;
	// largest number of allocations one pattern file may make
	localparam int MAX_SEQ        = 64;

	logic                   clock;
	logic                   reset;
	logic                   alu_valid;
	logic [ROB_TAG_LEN-1:0] alu_tag;
	logic [XLEN-1:0]        alu_value;
	logic                   alu_stall;
	logic                   st_valid;
	logic [ROB_TAG_LEN-1:0] st_tag;
	logic [XLEN-1:0]        st_value;
	logic                   st_stall;
	logic                   ld_valid;
	logic [ROB_TAG_LEN-1:0] ld_tag;
	logic [XLEN-1:0]        ld_value;
	logic                   ld_stall;
	logic                   alloc_valid;
	logic [REG_IDX_LEN-1:0] alloc_dest;
	logic                   alloc_store;
	logic [ROB_TAG_LEN-1:0] alloc_tag;
	logic                   rob_full;
	logic                   commit_valid;
	logic [ROB_TAG_LEN-1:0] commit_tag;
	logic [REG_IDX_LEN-1:0] commit_dest;
	logic [XLEN-1:0]        commit_value;
	logic                   commit_wr_en;

	// reference model, indexed by allocation sequence number
	logic [ROB_TAG_LEN-1:0] tag_of [MAX_SEQ];
	logic [REG_IDX_LEN-1:0] dest_of [MAX_SEQ];
	logic                   store_of [MAX_SEQ];
	logic [XLEN-1:0]        value_of [MAX_SEQ];
	// allocation order still waiting for commit
	int                     expect_q [$];
	// staged results per unit, 0 load, 1 alu, 2 store
	int                     pend [3][$];
	int                     seq_count;
	logic                   stall_seen;

	completion_unit UUT (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// failure reporting
	////////////////////////////////////////////////////////////
	task automatic abort_run(string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic compare_values(string what, logic [XLEN-1:0] got,
		logic [XLEN-1:0] expected);
		if (got !== expected) begin
			abort_run($sformatf("CHECK FAILED at time %0t: %s is %0h, expected %0h",
				$time, what, got, expected));
		end
	endtask

	////////////////////////////////////////////////////////////
	// result ports
	////////////////////////////////////////////////////////////
	function automatic logic unit_stall(int u);
		case (u)
			0:       return ld_stall;
			1:       return alu_stall;
			default: return st_stall;
		endcase
	endfunction

	// idle ports carry zero payload
	task automatic drive_unit(int u, logic valid, int s);
		case (u)
			0: begin
				ld_valid = valid;
				ld_tag   = valid ? tag_of[s] : '0;
				ld_value = valid ? value_of[s] : '0;
			end
			1: begin
				alu_valid = valid;
				alu_tag   = valid ? tag_of[s] : '0;
				alu_value = valid ? value_of[s] : '0;
			end
			default: begin
				st_valid = valid;
				st_tag   = valid ? tag_of[s] : '0;
				st_value = valid ? value_of[s] : '0;
			end
		endcase
	endtask

	// each unit sends its staged results as soon as its stall is low
	task automatic flush_results();
		int waited;
		waited = 0;
		while (pend[0].size() + pend[1].size() + pend[2].size() != 0) begin
			@(negedge clock);
			for (int u = 0; u < 3; u++) begin
				if (pend[u].size() != 0 && !unit_stall(u)) begin
					drive_unit(u, 1'b1, pend[u].pop_front());
				end else begin
					if (pend[u].size() != 0) begin
						stall_seen = 1'b1;
					end
					drive_unit(u, 1'b0, 0);
				end
			end
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				abort_run("timeout: a write-back slot never accepted a result");
			end
		end
		@(negedge clock);
		for (int u = 0; u < 3; u++) begin
			drive_unit(u, 1'b0, 0);
		end
	endtask

	////////////////////////////////////////////////////////////
	// allocation and draining
	////////////////////////////////////////////////////////////
	task automatic alloc_entry(int dest, int store);
		@(negedge clock);
		if (seq_count >= MAX_SEQ) begin
			abort_run("pattern file makes too many allocations");
		end
		alloc_valid = 1'b1;
		alloc_dest  = dest[REG_IDX_LEN-1:0];
		alloc_store = store[0];
		// tags go out in program order and wrap at ROB_DEPTH
		compare_values("alloc_tag", 32'(alloc_tag), seq_count % ROB_DEPTH);
		tag_of[seq_count]   = ROB_TAG_LEN'(seq_count % ROB_DEPTH);
		dest_of[seq_count]  = dest[REG_IDX_LEN-1:0];
		store_of[seq_count] = store[0];
		expect_q.push_back(seq_count);
		seq_count++;
		@(negedge clock);
		alloc_valid = 1'b0;
	endtask

	// allocation into a full ROB must leave the tail where it was
	task automatic alloc_while_full(int dest, int store);
		@(negedge clock);
		compare_values("rob_full before extra allocation", 32'(rob_full), 1);
		compare_values("alloc_tag before ignored allocation", 32'(alloc_tag),
			seq_count % ROB_DEPTH);
		alloc_valid = 1'b1;
		alloc_dest  = dest[REG_IDX_LEN-1:0];
		alloc_store = store[0];
		@(negedge clock);
		alloc_valid = 1'b0;
		compare_values("alloc_tag after ignored allocation", 32'(alloc_tag),
			seq_count % ROB_DEPTH);
		compare_values("rob_full after ignored allocation", 32'(rob_full), 1);
	endtask

	task automatic drain_commits();
		int waited;
		waited = 0;
		while (expect_q.size() != 0) begin
			@(negedge clock);
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				abort_run("timeout: outstanding entries never committed");
			end
		end
	endtask

	task automatic skip_line(int fd);
		int ch;
		ch = $fgetc(fd);
		while (ch != 10 && ch != -1) begin
			ch = $fgetc(fd);
		end
	endtask

	////////////////////////////////////////////////////////////
	// commit monitor
	////////////////////////////////////////////////////////////
	always @(negedge clock) begin
		int s;
		if (UUT.completion_chk_0.fail_count != 0) begin
			abort_run("an assertion in completion_chk failed");
		end
		if (!reset && commit_valid) begin
			if (expect_q.size() == 0) begin
				abort_run("commit seen while no entry was outstanding");
			end
			s = expect_q.pop_front();
			compare_values("commit_tag", 32'(commit_tag), 32'(tag_of[s]));
			compare_values("commit_dest", 32'(commit_dest), 32'(dest_of[s]));
			compare_values("commit_value", commit_value, value_of[s]);
			// stores and x0 never write the register file
			compare_values("commit_wr_en", 32'(commit_wr_en),
				32'(!store_of[s] && (dest_of[s] != '0)));
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	initial begin
		int fd;
		int code;
		int a;
		int b;
		logic [XLEN-1:0] v;
		string cmd;
		reset       = 1'b1;
		alloc_valid = 1'b0;
		alloc_dest  = '0;
		alloc_store = 1'b0;
		for (int u = 0; u < 3; u++) begin
			drive_unit(u, 1'b0, 0);
		end
		seq_count  = 0;
		stall_seen = 1'b0;
		fd = $fopen("verification/completion_patterns.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open verification/completion_patterns.txt");
		end
		repeat (16) @(negedge clock);
		reset = 1'b0;
		// state right after reset
		@(negedge clock);
		compare_values("ld_stall after reset", 32'(ld_stall), 0);
		compare_values("alu_stall after reset", 32'(alu_stall), 0);
		compare_values("st_stall after reset", 32'(st_stall), 0);
		compare_values("commit_valid after reset", 32'(commit_valid), 0);
		compare_values("rob_full after reset", 32'(rob_full), 0);
		compare_values("alloc_tag after reset", 32'(alloc_tag), 0);
		while ($fscanf(fd, "%s", cmd) == 1) begin
			if (cmd == "#") begin
				skip_line(fd);
			end else if (cmd == "result") begin
				// results are staged and leave at the next other command
				code = $fscanf(fd, "%d %d %h", a, b, v);
				if (code != 3 || a < 0 || a > 2 || b < 0 || b >= seq_count) begin
					abort_run("malformed result line in the pattern file");
				end
				value_of[b] = v;
				pend[a].push_back(b);
			end else begin
				flush_results();
				code = 0;
				if (cmd == "drain") begin
					code = 1;
					drain_commits();
				end else if (cmd == "alloc" || cmd == "reject") begin
					code = $fscanf(fd, "%d %d", a, b);
					if (code == 2 && cmd == "alloc") begin
						alloc_entry(a, b);
					end else if (code == 2) begin
						alloc_while_full(a, b);
					end
				end else if (cmd == "idle" || cmd == "full" || cmd == "stalled") begin
					code = $fscanf(fd, "%d", a);
					if (code == 1 && cmd == "idle") begin
						repeat (a) @(negedge clock);
					end else if (code == 1 && cmd == "full") begin
						@(negedge clock);
						compare_values("rob_full", 32'(rob_full), a);
					end else if (code == 1) begin
						compare_values("stall seen during results", 32'(stall_seen), a);
						stall_seen = 1'b0;
					end
				end
				if (code == 0) begin
					abort_run($sformatf("unknown or malformed pattern command %s", cmd));
				end
			end
		end
		$fclose(fd);
		flush_results();
		drain_commits();
		if (UUT.completion_chk_0.fail_count == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "assertion failures in completion_chk");
		end
	end

endmodule

//--- verification/completion_chk.sv
/*
 * assertions on CDB grants and ROB commit, bound into completion_unit
 * rob_count is the ROB occupancy, one bit wider than a tag
 */
`timescale 1ns/10ps

module completion_chk import completion_pkg::*; (
	input logic                 clock,
	input logic                 reset,
	input logic [2:0]           req,
	input logic [2:0]           grant,
	input logic                 commit_valid,
	input logic [ROB_TAG_LEN:0] rob_count
);

	// number of assertion failures so far
	int unsigned fail_count = 0;

	// at most one slot owns the CDB
	grant_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(grant))
		else begin
			fail_count++;
			$error("more than one CDB grant in a cycle");
		end

	// no grant without a pending request
	grant_to_req: assert property (@(posedge clock) disable iff (reset)
		(grant & ~req) == 3'b000)
		else begin
			fail_count++;
			$error("CDB grant to a slot that did not request");
		end

	// a commit retires a live entry, so the ROB was not empty at that edge
	commit_nonempty: assert property (@(posedge clock) disable iff (reset)
		commit_valid |-> ($past(rob_count) != '0))
		else begin
			fail_count++;
			$error("commit from an empty ROB");
		end

endmodule

bind completion_unit completion_chk completion_chk_0 (
	.clock(clock),
	.reset(reset),
	.req({st_req.req, alu_req.req, ld_req.req}),
	.grant({st_req.grant, alu_req.grant, ld_req.grant}),
	.commit_valid(commit_valid),
	.rob_count(rob_0.count)
);

//--- hw/completion_unit.sv
/*
 * completion top: three write-back slots, CDB arbiter and reorder buffer
 * result tags must come from alloc_tag; results for free entries are dropped
 */
`timescale 1ns/10ps

module completion_unit import completion_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,

	// alu result port
	input  logic                   alu_valid,
	input  logic [ROB_TAG_LEN-1:0] alu_tag,
	input  logic [XLEN-1:0]        alu_value,
	output logic                   alu_stall,

	// store address result port
	input  logic                   st_valid,
	input  logic [ROB_TAG_LEN-1:0] st_tag,
	input  logic [XLEN-1:0]        st_value,
	output logic                   st_stall,

	// load buffer result port
	input  logic                   ld_valid,
	input  logic [ROB_TAG_LEN-1:0] ld_tag,
	input  logic [XLEN-1:0]        ld_value,
	output logic                   ld_stall,

	// allocation in program order
	input  logic                   alloc_valid,
	input  logic [REG_IDX_LEN-1:0] alloc_dest,
	input  logic                   alloc_store,
	output logic [ROB_TAG_LEN-1:0] alloc_tag,
	output logic                   rob_full,

	// in-order commit
	output logic                   commit_valid,
	output logic [ROB_TAG_LEN-1:0] commit_tag,
	output logic [REG_IDX_LEN-1:0] commit_dest,
	output logic [XLEN-1:0]        commit_value,
	output logic                   commit_wr_en
);

	wb_result_t ld_result;
	wb_result_t alu_result;
	wb_result_t st_result;
	cdb_t       cdb;

	wb_req_if ld_req ();
	wb_req_if alu_req ();
	wb_req_if st_req ();

	// plain ports into result records
	assign ld_result  = '{valid: ld_valid, tag: ld_tag, value: ld_value};
	assign alu_result = '{valid: alu_valid, tag: alu_tag, value: alu_value};
	assign st_result  = '{valid: st_valid, tag: st_tag, value: st_value};

	////////////////////////////////////////////////////////////
	// write-back slots
	////////////////////////////////////////////////////////////
	wb_slot ld_slot (.clock(clock), .reset(reset), .in_result(ld_result),
		.stall(ld_stall), .bus(ld_req.slot));
	wb_slot alu_slot (.clock(clock), .reset(reset), .in_result(alu_result),
		.stall(alu_stall), .bus(alu_req.slot));
	wb_slot st_slot (.clock(clock), .reset(reset), .in_result(st_result),
		.stall(st_stall), .bus(st_req.slot));

	////////////////////////////////////////////////////////////
	// CDB and reorder buffer
	////////////////////////////////////////////////////////////
	cdb_arbiter cdb_arbiter_0 (.ld_bus(ld_req.arbiter), .alu_bus(alu_req.arbiter),
		.st_bus(st_req.arbiter), .cdb(cdb));

	rob rob_0 (
		.clock(clock),
		.reset(reset),
		.alloc_valid(alloc_valid),
		.alloc_store(alloc_store),
		.alloc_dest(alloc_dest),
		.cdb(cdb),
		.alloc_tag(alloc_tag),
		.full(rob_full),
		.commit_valid(commit_valid),
		.commit_wr_en(commit_wr_en),
		.commit_tag(commit_tag),
		.commit_dest(commit_dest),
		.commit_value(commit_value)
	);

endmodule

//--- hw/rob.sv
/*
 * reorder buffer, tags handed out in program order and retired in order
 * allocation while full is dropped; at most one commit per cycle
 */
`timescale 1ns/10ps

module rob import completion_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   alloc_valid,
	input  logic                   alloc_store,
	input  logic [REG_IDX_LEN-1:0] alloc_dest,
	input  cdb_t                   cdb,
	output logic [ROB_TAG_LEN-1:0] alloc_tag,
	output logic                   full,
	output logic                   commit_valid,
	output logic                   commit_wr_en,
	output logic [ROB_TAG_LEN-1:0] commit_tag,
	output logic [REG_IDX_LEN-1:0] commit_dest,
	output logic [XLEN-1:0]        commit_value
);

	////////////////////////////////////////////////////////////
	// storage and pointers
	////////////////////////////////////////////////////////////
	rob_entry_t             entries [ROB_DEPTH];
	logic [ROB_TAG_LEN-1:0] head;
	logic [ROB_TAG_LEN-1:0] tail;
	// one extra bit so a full buffer is distinct from empty
	logic [ROB_TAG_LEN:0]   count;

	rob_entry_t head_entry;
	logic       do_alloc;
	logic       do_commit;

	assign head_entry = entries[head];
	assign full       = (count == ROB_DEPTH);
	assign alloc_tag  = tail;

	assign do_alloc  = alloc_valid & ~full;
	// busy check keeps a stale ready bit from retiring
	assign do_commit = head_entry.busy & head_entry.ready;

	////////////////////////////////////////////////////////////
	// entry updates
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ROB_DEPTH; i++) begin
				entries[i].busy  <= 1'b0;
				entries[i].ready <= 1'b0;
			end
		end else begin
			// capture from the CDB, only into a live entry
			if (cdb.valid && entries[cdb.tag].busy) begin
				entries[cdb.tag].ready <= 1'b1;
				entries[cdb.tag].value <= cdb.value;
			end
			// retire frees the head
			if (do_commit) begin
				entries[head].busy  <= 1'b0;
				entries[head].ready <= 1'b0;
			end
			// tail never equals a busy head when allocation is allowed
			if (do_alloc) begin
				entries[tail].busy  <= 1'b1;
				entries[tail].ready <= 1'b0;
				entries[tail].store <= alloc_store;
				entries[tail].dest  <= alloc_dest;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (do_alloc) begin
				tail <= tail + 1'b1;
			end
			if (do_commit) begin
				head <= head + 1'b1;
			end
			case ({do_alloc, do_commit})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// commit outputs, registered
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid <= 1'b0;
			commit_wr_en <= 1'b0;
		end else begin
			commit_valid <= do_commit;
			// stores and x0 never reach the register file
			commit_wr_en <= do_commit & ~head_entry.store & (head_entry.dest != '0);
		end
	end

	// payload follows the head, meaningful with commit_valid only
	always_ff @(posedge clock) begin
		if (do_commit) begin
			commit_tag   <= head;
			commit_dest  <= head_entry.dest;
			commit_value <= head_entry.value;
		end
	end

endmodule

//--- hw/cdb_arbiter.sv
/*
 * combinational fixed priority CDB arbiter, load then alu then store
 * losers are not queued; their slots simply keep requesting
 */
`timescale 1ns/10ps

module cdb_arbiter import completion_pkg::*; (
	wb_req_if.arbiter ld_bus,
	wb_req_if.arbiter alu_bus,
	wb_req_if.arbiter st_bus,
	output cdb_t      cdb
);

	// bit 0 load, bit 1 alu, bit 2 store
	logic [2:0] req_vec;
	logic [2:0] grant_vec;
	wb_result_t winner;

	assign req_vec = {st_bus.req, alu_bus.req, ld_bus.req};

	// lowest index wins
	assign grant_vec[0] = req_vec[0];
	assign grant_vec[1] = req_vec[1] & ~req_vec[0];
	assign grant_vec[2] = req_vec[2] & ~|req_vec[1:0];

	assign ld_bus.grant  = grant_vec[0];
	assign alu_bus.grant = grant_vec[1];
	assign st_bus.grant  = grant_vec[2];

	// winner mux, idle bus when nobody asks
	always_comb begin
		winner = '0;
		if (grant_vec[0]) begin
			winner = '{valid: 1'b1, tag: ld_bus.tag, value: ld_bus.value};
		end else if (grant_vec[1]) begin
			winner = '{valid: 1'b1, tag: alu_bus.tag, value: alu_bus.value};
		end else if (grant_vec[2]) begin
			winner = '{valid: 1'b1, tag: st_bus.tag, value: st_bus.value};
		end
	end

	assign cdb = '{valid: winner.valid, tag: winner.tag, value: winner.value};

endmodule

//--- hw/wb_slot.sv
/*
 * write-back holding register for one execution unit
 * unit may pulse in_result.valid only while stall is low
 */
`timescale 1ns/10ps

module wb_slot import completion_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  wb_result_t in_result,
	output logic       stall,
	wb_req_if.slot     bus
);

	// held result, valid bit doubles as occupancy
	wb_result_t held;
	logic       accept;

	////////////////////////////////////////////////////////////
	// hazard
	////////////////////////////////////////////////////////////

	// busy unless the held result leaves this cycle
	assign stall  = held.valid & ~bus.grant;
	assign accept = in_result.valid & ~stall;

	////////////////////////////////////////////////////////////
	// holding register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			held.valid <= 1'b0;
		end else if (accept) begin
			// a granted result is replaced at the same edge
			held <= in_result;
		end else if (bus.grant) begin
			held.valid <= 1'b0;
		end
	end

	// present to the arbiter from the next cycle on
	assign bus.req   = held.valid;
	assign bus.tag   = held.tag;
	assign bus.value = held.value;

endmodule

//--- hw/wb_req_if.sv
/*
 * request path from one holding register to the CDB arbiter
 * req stays up with stable tag and value until grant is seen high
 */
`timescale 1ns/10ps

interface wb_req_if import completion_pkg::*; ();

	// slot side
	logic                   req;
	logic [ROB_TAG_LEN-1:0] tag;
	logic [XLEN-1:0]        value;

	// arbiter side
	logic                   grant;

	modport slot (
		output req, tag, value,
		input  grant
	);

	modport arbiter (
		input  req, tag, value,
		output grant
	);

endinterface

//--- hw/completion_pkg.sv
/*
 * shared sizes and types for the completion side
 * ROB_TAG_LEN must stay log2(ROB_DEPTH); tags wrap by plain overflow
 */
package completion_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////
	localparam int XLEN        = 32;
	localparam int ROB_DEPTH   = 8;
	localparam int ROB_TAG_LEN = 3;
	localparam int REG_IDX_LEN = 5;

	////////////////////////////////////////////////////////////
	// result and bus formats
	////////////////////////////////////////////////////////////

	// one execution unit result, same for alu, store and load
	typedef struct packed {
		logic                   valid;
		logic [ROB_TAG_LEN-1:0] tag;
		logic [XLEN-1:0]        value;
	} wb_result_t;

	// common data bus broadcast
	typedef struct packed {
		logic                   valid;
		logic [ROB_TAG_LEN-1:0] tag;
		logic [XLEN-1:0]        value;
	} cdb_t;

	// one reorder buffer entry
	typedef struct packed {
		logic                   busy;
		logic                   ready;
		logic                   store;
		logic [REG_IDX_LEN-1:0] dest;
		logic [XLEN-1:0]        value;
	} rob_entry_t;

endpackage
